// ==== design/wisc_pkg.sv ====
`default_nettype none

package wisc_pkg;

   localparam int WORD_W    = 16;
   localparam int REG_IDX_W = 3;
   localparam int SHAMT_W   = 4;  // shifts and rotates use the low bits of operand b
   localparam int BYTE_W    = 8;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,  // operand b minus operand a
      ALU_XOR  = 4'd2,
      ALU_ANDN = 4'd3,
      ALU_ROL  = 4'd4,
      ALU_SLL  = 4'd5,
      ALU_ROR  = 4'd6,
      ALU_SRL  = 4'd7,
      ALU_SLBI = 4'd8
   } alu_op_t;

   typedef enum logic [2:0] {
      BR_NONE = 3'd0,
      BR_EQZ  = 3'd1,
      BR_NEZ  = 3'd2,
      BR_LTZ  = 3'd3,
      BR_GEZ  = 3'd4,
      BR_J    = 3'd5,
      BR_JR   = 3'd6
   } br_kind_t;

   typedef enum logic [1:0] {
      SET_EQ = 2'd0,
      SET_LT = 2'd1,
      SET_LE = 2'd2,
      SET_CO = 2'd3
   } set_sel_t;

   typedef enum logic [2:0] {
      WB_ALU    = 3'd0,
      WB_MEM    = 3'd1,
      WB_PC_INC = 3'd2,
      WB_SET    = 3'd3,
      WB_IMM    = 3'd4   // lbi writes the sign-extended immediate
   } wr_sel_t;

endpackage

`default_nettype wire

// ==== design/alu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
   input  wire  wisc_pkg::word_t    pc_inc,
   input  wire  wisc_pkg::word_t    rd_data_1,
   input  wire  wisc_pkg::word_t    rd_data_2,
   input  wire  wisc_pkg::word_t    sext_imm,
   input  wire  wisc_pkg::alu_op_t  alu_op,
   input  wire                      alu_src_imm,
   input  wire  wisc_pkg::br_kind_t br_kind,
   input  wire  wisc_pkg::set_sel_t set_sel,
   input  wire                      issue_valid,
   output logic                     alu_out_unused_guard_n,
   output wisc_pkg::word_t          alu_out,
   output logic                     set_bit,
   output logic                     take_new_pc,
   output wisc_pkg::word_t          new_pc
);

   localparam int W = wisc_pkg::WORD_W;

   wisc_pkg::word_t                op_a;
   wisc_pkg::word_t                op_b;
   logic [wisc_pkg::SHAMT_W-1:0]   shamt;
   logic [2*W-1:0]                 rot_l;
   logic [2*W-1:0]                 rot_r;
   logic [W:0]                     sum_full;
   wisc_pkg::word_t                diff;
   logic                           diff_ofl;
   logic                           lt_flag;
   logic                           eq_flag;
   logic                           a_zero;
   logic                           a_neg;
   logic                           br_taken;

   assign op_a  = rd_data_1;
   assign op_b  = alu_src_imm ? sext_imm : rd_data_2;
   assign shamt = op_b[wisc_pkg::SHAMT_W-1:0];

   // rotates come out of a doubled copy of operand a
   assign rot_l = {op_a, op_a} << shamt;
   assign rot_r = {op_a, op_a} >> shamt;

   assign sum_full = {1'b0, op_a} + {1'b0, op_b};

   // a - b drives the signed compares of the set conditions
   assign diff     = op_a - op_b;
   assign diff_ofl = (op_a[W-1] != op_b[W-1]) && (diff[W-1] != op_a[W-1]);
   assign lt_flag  = diff[W-1] ^ diff_ofl;
   assign eq_flag  = (diff == '0);

   always_comb begin
      case (alu_op)
         wisc_pkg::ALU_ADD:  alu_out = sum_full[W-1:0];
         wisc_pkg::ALU_SUB:  alu_out = op_b - op_a;
         wisc_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
         wisc_pkg::ALU_ANDN: alu_out = op_a & ~op_b;
         wisc_pkg::ALU_ROL:  alu_out = rot_l[2*W-1:W];
         wisc_pkg::ALU_SLL:  alu_out = op_a << shamt;
         wisc_pkg::ALU_ROR:  alu_out = rot_r[W-1:0];
         wisc_pkg::ALU_SRL:  alu_out = op_a >> shamt;
         wisc_pkg::ALU_SLBI: begin
            alu_out = {op_a[W-wisc_pkg::BYTE_W-1:0], op_b[wisc_pkg::BYTE_W-1:0]};
         end
         default:            alu_out = sum_full[W-1:0];
      endcase
   end

   always_comb begin
      case (set_sel)
         wisc_pkg::SET_EQ: set_bit = eq_flag;
         wisc_pkg::SET_LT: set_bit = lt_flag;
         wisc_pkg::SET_LE: set_bit = lt_flag | eq_flag;
         wisc_pkg::SET_CO: set_bit = sum_full[W];  // carry out of a + b
         default:          set_bit = 1'b0;
      endcase
   end

   assign a_zero = (rd_data_1 == '0);
   assign a_neg  = rd_data_1[W-1];

   always_comb begin
      case (br_kind)
         wisc_pkg::BR_EQZ: br_taken = a_zero;
         wisc_pkg::BR_NEZ: br_taken = ~a_zero;
         wisc_pkg::BR_LTZ: br_taken = a_neg;
         wisc_pkg::BR_GEZ: br_taken = ~a_neg;
         wisc_pkg::BR_J:   br_taken = 1'b1;
         wisc_pkg::BR_JR:  br_taken = 1'b1;
         default:          br_taken = 1'b0;
      endcase
   end

   // jr is register relative, every other kind is pc relative
   assign new_pc = (br_kind == wisc_pkg::BR_JR) ? rd_data_1 + sext_imm : pc_inc + sext_imm;

   assign take_new_pc = issue_valid & br_taken;  // an empty slot never redirects

   assign alu_out_unused_guard_n = 1'b1;

endmodule

`default_nettype wire

// ==== design/ex_mem_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
   input  wire                       clk,
   input  wire                       arst_n,
   input  wire                       issue_valid,
   input  wire                       take_new_pc,
   input  wire  wisc_pkg::word_t     new_pc,
   input  wire  wisc_pkg::word_t     pc_inc,
   input  wire  wisc_pkg::word_t     rd_data_2,
   input  wire  wisc_pkg::word_t     alu_out,
   input  wire  wisc_pkg::word_t     sext_imm,
   input  wire                       set_bit,
   input  wire                       mem_en,
   input  wire                       mem_wr,
   input  wire                       wr_en,
   input  wire                       halt_req,
   input  wire  wisc_pkg::reg_idx_t  wr_reg,
   input  wire  wisc_pkg::wr_sel_t   wr_sel,
   output logic                      ex_valid,
   output logic                      redirect_valid,
   output wisc_pkg::word_t           redirect_pc,
   output wisc_pkg::word_t           pc_inc_q,
   output wisc_pkg::word_t           rd_data_2_q,
   output wisc_pkg::word_t           alu_out_q,
   output wisc_pkg::word_t           sext_imm_q,
   output logic                      set_bit_q,
   output logic                      mem_en_q,
   output logic                      mem_wr_q,
   output logic                      wr_en_q,
   output logic                      halt_q,
   output wisc_pkg::reg_idx_t        wr_reg_q,
   output wisc_pkg::wr_sel_t         wr_sel_q
);

   // the slot right behind a taken branch is on the wrong path
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_valid       <= 1'b0;
         redirect_valid <= 1'b0;
      end else begin
         ex_valid       <= issue_valid & ~redirect_valid;
         redirect_valid <= take_new_pc & ~redirect_valid;  // a squashed branch cannot redirect
      end
   end

   always_ff @(posedge clk) begin
      redirect_pc <= new_pc;
   end

   // payload is held across bubbles
   always_ff @(posedge clk) begin
      if (issue_valid) begin
         pc_inc_q    <= pc_inc;
         rd_data_2_q <= rd_data_2;
         alu_out_q   <= alu_out;
         sext_imm_q  <= sext_imm;
         set_bit_q   <= set_bit;
         mem_en_q    <= mem_en;
         mem_wr_q    <= mem_wr;
         wr_en_q     <= wr_en;
         halt_q      <= halt_req;
         wr_reg_q    <= wr_reg;
         wr_sel_q    <= wr_sel;
      end
   end

endmodule

`default_nettype wire

// ==== design/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
   parameter int unsigned DMEM_WORDS = 256  // power of two
) (
   input  wire                    clk,
   input  wire  wisc_pkg::word_t  addr,
   input  wire  wisc_pkg::word_t  wdata,
   input  wire                    we,
   output wisc_pkg::word_t        rdata
);

   localparam int ADDR_W = $clog2(DMEM_WORDS);

   wisc_pkg::word_t    mem [DMEM_WORDS];
   logic [ADDR_W-1:0]  word_addr;

   assign word_addr = addr[ADDR_W-1:0];  // upper address bits alias

   always_ff @(posedge clk) begin
      if (we) begin
         mem[word_addr] <= wdata;
      end
   end

   assign rdata = mem[word_addr];  // asynchronous read sees last edge's store

endmodule

`default_nettype wire

// ==== design/mem_wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
   input  wire                       clk,
   input  wire                       arst_n,
   input  wire                       ex_valid,
   input  wire  wisc_pkg::word_t     alu_out_q,
   input  wire  wisc_pkg::word_t     mem_rdata,
   input  wire  wisc_pkg::word_t     pc_inc_q,
   input  wire  wisc_pkg::word_t     sext_imm_q,
   input  wire                       set_bit_q,
   input  wire                       wr_en_q,
   input  wire                       halt_q,
   input  wire  wisc_pkg::reg_idx_t  wr_reg_q,
   input  wire  wisc_pkg::wr_sel_t   wr_sel_q,
   output logic                      rf_wr_en,
   output wisc_pkg::reg_idx_t        rf_wr_reg,
   output wisc_pkg::word_t           rf_wr_data,
   output logic                      halted
);

   wisc_pkg::word_t     wb_data;
   logic                wb_valid;
   logic                wb_wr_en;
   wisc_pkg::word_t     wb_data_q;
   wisc_pkg::reg_idx_t  wb_reg_q;

   always_comb begin
      case (wr_sel_q)
         wisc_pkg::WB_ALU:    wb_data = alu_out_q;
         wisc_pkg::WB_MEM:    wb_data = mem_rdata;
         wisc_pkg::WB_PC_INC: wb_data = pc_inc_q;
         wisc_pkg::WB_SET:    wb_data = {{(wisc_pkg::WORD_W-1){1'b0}}, set_bit_q};
         wisc_pkg::WB_IMM:    wb_data = sext_imm_q;
         default:             wb_data = alu_out_q;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_valid <= 1'b0;
         halted   <= 1'b0;
      end else begin
         wb_valid <= ex_valid;
         halted   <= halted | (ex_valid & halt_q);  // sticky until reset
      end
   end

   always_ff @(posedge clk) begin
      if (ex_valid) begin
         wb_wr_en  <= wr_en_q;
         wb_data_q <= wb_data;
         wb_reg_q  <= wr_reg_q;
      end
   end

   // the halt itself and everything behind it never write
   assign rf_wr_en   = wb_valid & wb_wr_en & ~halted;
   assign rf_wr_reg  = wb_reg_q;
   assign rf_wr_data = wb_data_q;

endmodule

`default_nettype wire

// ==== design/wisc_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module wisc_backend #(
   parameter int unsigned DMEM_WORDS = 256
) (
   input  wire                       clk,
   input  wire                       arst_n,
   input  wire                       issue_valid,
   input  wire  wisc_pkg::word_t     pc_inc,
   input  wire  wisc_pkg::word_t     rd_data_1,
   input  wire  wisc_pkg::word_t     rd_data_2,
   input  wire  wisc_pkg::word_t     sext_imm,
   input  wire  wisc_pkg::alu_op_t   alu_op,
   input  wire                       alu_src_imm,
   input  wire  wisc_pkg::br_kind_t  br_kind,
   input  wire  wisc_pkg::set_sel_t  set_sel,
   input  wire                       mem_en,
   input  wire                       mem_wr,
   input  wire                       wr_en,
   input  wire  wisc_pkg::reg_idx_t  wr_reg,
   input  wire  wisc_pkg::wr_sel_t   wr_sel,
   input  wire                       halt_req,
   output logic                      redirect_valid,
   output wisc_pkg::word_t           redirect_pc,
   output logic                      rf_wr_en,
   output wisc_pkg::reg_idx_t        rf_wr_reg,
   output wisc_pkg::word_t           rf_wr_data,
   output logic                      halted
);

   wisc_pkg::word_t     alu_out;
   logic                set_bit;
   logic                take_new_pc;
   wisc_pkg::word_t     new_pc;

   logic                ex_valid;
   wisc_pkg::word_t     pc_inc_q;
   wisc_pkg::word_t     rd_data_2_q;
   wisc_pkg::word_t     alu_out_q;
   wisc_pkg::word_t     sext_imm_q;
   logic                set_bit_q;
   logic                mem_en_q;
   logic                mem_wr_q;
   logic                wr_en_q;
   logic                halt_q;
   wisc_pkg::reg_idx_t  wr_reg_q;
   wisc_pkg::wr_sel_t   wr_sel_q;

   wisc_pkg::word_t     mem_rdata;
   logic                dmem_we;

   alu_exec i_alu_exec (
      .pc_inc                 (pc_inc),
      .rd_data_1              (rd_data_1),
      .rd_data_2              (rd_data_2),
      .sext_imm               (sext_imm),
      .alu_op                 (alu_op),
      .alu_src_imm            (alu_src_imm),
      .br_kind                (br_kind),
      .set_sel                (set_sel),
      .issue_valid            (issue_valid),
      .alu_out_unused_guard_n (),
      .alu_out                (alu_out),
      .set_bit                (set_bit),
      .take_new_pc            (take_new_pc),
      .new_pc                 (new_pc)
   );

   ex_mem_reg i_ex_mem_reg (
      .clk            (clk),
      .arst_n         (arst_n),
      .issue_valid    (issue_valid),
      .take_new_pc    (take_new_pc),
      .new_pc         (new_pc),
      .pc_inc         (pc_inc),
      .rd_data_2      (rd_data_2),
      .alu_out        (alu_out),
      .sext_imm       (sext_imm),
      .set_bit        (set_bit),
      .mem_en         (mem_en),
      .mem_wr         (mem_wr),
      .wr_en          (wr_en),
      .halt_req       (halt_req),
      .wr_reg         (wr_reg),
      .wr_sel         (wr_sel),
      .ex_valid       (ex_valid),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .pc_inc_q       (pc_inc_q),
      .rd_data_2_q    (rd_data_2_q),
      .alu_out_q      (alu_out_q),
      .sext_imm_q     (sext_imm_q),
      .set_bit_q      (set_bit_q),
      .mem_en_q       (mem_en_q),
      .mem_wr_q       (mem_wr_q),
      .wr_en_q        (wr_en_q),
      .halt_q         (halt_q),
      .wr_reg_q       (wr_reg_q),
      .wr_sel_q       (wr_sel_q)
   );

   // a store only lands for a live instruction in the memory stage
   assign dmem_we = ex_valid & mem_en_q & mem_wr_q;

   data_mem #(
      .DMEM_WORDS (DMEM_WORDS)
   ) i_data_mem (
      .clk   (clk),
      .addr  (alu_out_q),
      .wdata (rd_data_2_q),
      .we    (dmem_we),
      .rdata (mem_rdata)
   );

   mem_wb_stage i_mem_wb_stage (
      .clk        (clk),
      .arst_n     (arst_n),
      .ex_valid   (ex_valid),
      .alu_out_q  (alu_out_q),
      .mem_rdata  (mem_rdata),
      .pc_inc_q   (pc_inc_q),
      .sext_imm_q (sext_imm_q),
      .set_bit_q  (set_bit_q),
      .wr_en_q    (wr_en_q),
      .halt_q     (halt_q),
      .wr_reg_q   (wr_reg_q),
      .wr_sel_q   (wr_sel_q),
      .rf_wr_en   (rf_wr_en),
      .rf_wr_reg  (rf_wr_reg),
      .rf_wr_data (rf_wr_data),
      .halted     (halted)
   );

endmodule

`default_nettype wire

// ==== test/tb_wisc_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wisc_backend;

   localparam int DMEM_WORDS = 256;
   localparam int NEVER      = 32'h7fff_ffff;
   // alu, set, load/store, branch, bubble and halt tests, then resets and drain
   localparam int TEST_CYCLES = 36 + 24 + 23 + 84 + 40 + 17 + 8;

   logic                clk;
   logic                arst_n;
   logic                issue_valid;
   wisc_pkg::word_t     pc_inc;
   wisc_pkg::word_t     rd_data_1;
   wisc_pkg::word_t     rd_data_2;
   wisc_pkg::word_t     sext_imm;
   wisc_pkg::alu_op_t   alu_op;
   logic                alu_src_imm;
   wisc_pkg::br_kind_t  br_kind;
   wisc_pkg::set_sel_t  set_sel;
   logic                mem_en;
   logic                mem_wr;
   logic                wr_en;
   wisc_pkg::reg_idx_t  wr_reg;
   wisc_pkg::wr_sel_t   wr_sel;
   logic                halt_req;
   logic                redirect_valid;
   wisc_pkg::word_t     redirect_pc;
   logic                rf_wr_en;
   wisc_pkg::reg_idx_t  rf_wr_reg;
   wisc_pkg::word_t     rf_wr_data;
   logic                halted;

   int                  cyc;
   int                  halt_cyc;
   int                  last_taken;
   int                  exp_cyc[$];
   wisc_pkg::reg_idx_t  exp_reg[$];
   wisc_pkg::word_t     exp_data[$];
   int                  redir_cyc[$];
   wisc_pkg::word_t     redir_pc[$];
   wisc_pkg::word_t     mem_img[int];

   wisc_backend #(.DMEM_WORDS(DMEM_WORDS)) i_wisc_backend (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic stop_with_error(input string msg);
      $display("[ERROR] %0t: %s", $time, msg);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   function automatic wisc_pkg::word_t alu_result(input wisc_pkg::alu_op_t op,
         input wisc_pkg::word_t a, input wisc_pkg::word_t b);
      int s;
      s = b[3:0];
      case (op)
         wisc_pkg::ALU_ADD:  return a + b;
         wisc_pkg::ALU_SUB:  return b - a;
         wisc_pkg::ALU_XOR:  return a ^ b;
         wisc_pkg::ALU_ANDN: return a & ~b;
         wisc_pkg::ALU_ROL:  return (a << s) | (a >> (16 - s));
         wisc_pkg::ALU_SLL:  return a << s;
         wisc_pkg::ALU_ROR:  return (a >> s) | (a << (16 - s));
         wisc_pkg::ALU_SRL:  return a >> s;
         default:            return (a << 8) | (b & 16'h00ff);
      endcase
   endfunction

   function automatic logic set_result(input wisc_pkg::set_sel_t ss,
         input wisc_pkg::word_t a, input wisc_pkg::word_t b);
      case (ss)
         wisc_pkg::SET_EQ: return a == b;
         wisc_pkg::SET_LT: return $signed(a) < $signed(b);
         wisc_pkg::SET_LE: return $signed(a) <= $signed(b);
         default:          return (a + b) < a;  // the 16-bit sum wraps exactly on a carry
      endcase
   endfunction

   function automatic logic branch_taken(input wisc_pkg::br_kind_t br, input wisc_pkg::word_t a);
      case (br)
         wisc_pkg::BR_EQZ:              return a == 0;
         wisc_pkg::BR_NEZ:              return a != 0;
         wisc_pkg::BR_LTZ:              return $signed(a) < 0;
         wisc_pkg::BR_GEZ:              return $signed(a) >= 0;
         wisc_pkg::BR_J, wisc_pkg::BR_JR: return 1'b1;
         default:                       return 1'b0;
      endcase
   endfunction

   task automatic check_outputs();
      if (rf_wr_en === 1'b1) begin
         assert (exp_cyc.size() > 0 && exp_cyc[0] == cyc)
            else stop_with_error($sformatf("unexpected write to r%0d", rf_wr_reg));
         assert (rf_wr_reg == exp_reg[0] && rf_wr_data == exp_data[0])
            else stop_with_error($sformatf("write r%0d=%h, expected r%0d=%h",
               rf_wr_reg, rf_wr_data, exp_reg[0], exp_data[0]));
         void'(exp_cyc.pop_front());
         void'(exp_reg.pop_front());
         void'(exp_data.pop_front());
      end else begin
         assert (rf_wr_en === 1'b0) else stop_with_error("rf_wr_en is neither 0 nor 1");
         assert (exp_cyc.size() == 0 || exp_cyc[0] > cyc)
            else stop_with_error($sformatf("missing write to r%0d", exp_reg[0]));
      end
      if (redirect_valid === 1'b1) begin
         assert (redir_cyc.size() > 0 && redir_cyc[0] == cyc)
            else stop_with_error("redirect_valid raised without a taken branch");
         assert (redirect_pc == redir_pc[0])
            else stop_with_error($sformatf("redirect_pc %h, expected %h", redirect_pc, redir_pc[0]));
         void'(redir_cyc.pop_front());
         void'(redir_pc.pop_front());
      end else begin
         assert (redir_cyc.size() == 0 || redir_cyc[0] > cyc)
            else stop_with_error("redirect_valid stayed low after a taken branch");
      end
      assert (halted === (cyc >= halt_cyc))
         else stop_with_error($sformatf("halted is %b in cycle %0d", halted, cyc));
   endtask

   always @(negedge clk) begin
      if (cyc > 0) begin
         check_outputs();
      end
   end

   task automatic issue(
      input wisc_pkg::alu_op_t  op,
      input logic               src_imm,
      input wisc_pkg::word_t    a,
      input wisc_pkg::word_t    b,
      input wisc_pkg::word_t    imm,
      input wisc_pkg::reg_idx_t rd,
      input wisc_pkg::wr_sel_t  ws,
      input wisc_pkg::br_kind_t br,
      input wisc_pkg::set_sel_t ss,
      input logic               men,
      input logic               mwr,
      input logic               wen,
      input logic               halt
   );
      wisc_pkg::word_t opb;
      wisc_pkg::word_t res;
      wisc_pkg::word_t pc;
      wisc_pkg::word_t wb;
      pc  = $urandom;
      opb = src_imm ? imm : b;
      res = alu_result(op, a, opb);
      @(posedge clk);
      #2;
      issue_valid = 1'b1;
      {pc_inc, rd_data_1, rd_data_2, sext_imm} = {pc, a, b, imm};
      {alu_src_imm, mem_en, mem_wr, wr_en, halt_req, wr_reg} = {src_imm, men, mwr, wen, halt, rd};
      alu_op  = op;
      br_kind = br;
      set_sel = ss;
      wr_sel  = ws;
      if (last_taken != cyc - 1) begin  // the slot behind a taken branch is discarded
         if (branch_taken(br, a)) begin
            redir_cyc.push_back(cyc + 1);
            redir_pc.push_back((br == wisc_pkg::BR_JR) ? a + imm : pc + imm);
            last_taken = cyc;
         end
         if (men && mwr) begin
            mem_img[res % DMEM_WORDS] = b;
         end
         case (ws)
            wisc_pkg::WB_MEM:    wb = mem_img[res % DMEM_WORDS];
            wisc_pkg::WB_PC_INC: wb = pc;
            wisc_pkg::WB_SET:    wb = {15'd0, set_result(ss, a, opb)};
            wisc_pkg::WB_IMM:    wb = imm;
            default:             wb = res;
         endcase
         if (halt && halt_cyc == NEVER) begin
            halt_cyc = cyc + 2;
         end
         if (wen && halt_cyc == NEVER) begin
            exp_cyc.push_back(cyc + 2);
            exp_reg.push_back(rd);
            exp_data.push_back(wb);
         end
      end
   endtask

   task automatic insert_bubbles(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
         issue_valid = 1'b0;
         rd_data_1   = $urandom;  // fields of an empty slot must not matter
         wr_en       = 1'b1;
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #2;
      arst_n      = 1'b0;
      issue_valid = 1'b0;
      halt_cyc    = NEVER;
      last_taken  = -10;
      repeat (3) @(posedge clk);
      #2;
      arst_n = 1'b1;
   endtask

   task automatic test_alu_ops();
      for (int i = 0; i < 9; i++) begin
         for (int k = 0; k < 4; k++) begin
            issue(wisc_pkg::alu_op_t'(i), k[0], $urandom, $urandom, $urandom, $urandom,
               wisc_pkg::WB_ALU, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ, 1'b0, 1'b0, 1'b1, 1'b0);
         end
      end
   endtask

   task automatic test_set_and_imm();
      wisc_pkg::word_t a_vals[5] = '{16'h0005, 16'h8000, 16'hfffe, 16'hffff, 16'h7fff};
      wisc_pkg::word_t b_vals[5] = '{16'h0005, 16'h0001, 16'hffff, 16'h0001, 16'h8001};
      for (int s = 0; s < 4; s++) begin
         for (int p = 0; p < 5; p++) begin
            issue(wisc_pkg::ALU_ADD, p[0], a_vals[p], b_vals[p], b_vals[p], $urandom,
               wisc_pkg::WB_SET, wisc_pkg::BR_NONE, wisc_pkg::set_sel_t'(s),
               1'b0, 1'b0, 1'b1, 1'b0);
         end
      end
      for (int k = 0; k < 4; k++) begin
         issue(wisc_pkg::ALU_XOR, 1'b0, $urandom, $urandom, $urandom, $urandom,
            k[0] ? wisc_pkg::WB_IMM : wisc_pkg::WB_PC_INC, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ,
            1'b0, 1'b0, 1'b1, 1'b0);
      end
   endtask

   task automatic test_load_store();
      wisc_pkg::word_t addr[6];
      wisc_pkg::word_t base;
      for (int k = 0; k < 6; k++) begin
         addr[k] = $urandom % DMEM_WORDS;
         base    = $urandom;
         issue(wisc_pkg::ALU_ADD, 1'b1, base, $urandom, addr[k] - base, $urandom,
            wisc_pkg::WB_ALU, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ, 1'b1, 1'b1, 1'b0, 1'b0);
         if (k % 2 == 1) begin
            insert_bubbles(1);
         end
         issue(wisc_pkg::ALU_ADD, 1'b1, addr[k], $urandom, 16'h0000, $urandom,
            wisc_pkg::WB_MEM, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ, 1'b1, 1'b0, 1'b1, 1'b0);
      end
      insert_bubbles(2);
      // reload through aliased addresses, upper bits are ignored by the memory
      for (int k = 5; k >= 0; k--) begin
         issue(wisc_pkg::ALU_ADD, 1'b1, addr[k] + k * DMEM_WORDS, $urandom, 16'h0000, $urandom,
            wisc_pkg::WB_MEM, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ, 1'b1, 1'b0, 1'b1, 1'b0);
      end
   endtask

   task automatic test_branches();
      wisc_pkg::word_t vals[3] = '{16'h0000, 16'h0123, 16'hf00d};
      for (int i = 0; i < 7; i++) begin
         for (int v = 0; v < 3; v++) begin
            issue(wisc_pkg::ALU_ADD, 1'b0, vals[v], $urandom, $urandom, $urandom,
               wisc_pkg::WB_ALU, wisc_pkg::br_kind_t'(i), wisc_pkg::SET_EQ,
               1'b0, 1'b0, 1'b0, 1'b0);
            issue(wisc_pkg::ALU_XOR, 1'b0, $urandom, $urandom, $urandom, $urandom,
               wisc_pkg::WB_ALU, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ, 1'b0, 1'b0, 1'b1, 1'b0);
            issue(wisc_pkg::ALU_SUB, 1'b0, $urandom, $urandom, $urandom, $urandom,
               wisc_pkg::WB_ALU, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ, 1'b0, 1'b0, 1'b1, 1'b0);
            insert_bubbles(1);
         end
      end
   endtask

   task automatic test_bubbles();
      repeat (10) begin
         issue(wisc_pkg::alu_op_t'($urandom % 9), 1'b0, $urandom, $urandom, $urandom, $urandom,
            wisc_pkg::WB_ALU, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ, 1'b0, 1'b0, 1'b1, 1'b0);
         insert_bubbles($urandom % 4);
      end
   endtask

   task automatic test_halt();
      issue(wisc_pkg::ALU_XOR, 1'b0, $urandom, $urandom, $urandom, $urandom,
         wisc_pkg::WB_ALU, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ, 1'b0, 1'b0, 1'b1, 1'b0);
      issue(wisc_pkg::ALU_ADD, 1'b0, $urandom, $urandom, $urandom, $urandom,
         wisc_pkg::WB_ALU, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ, 1'b0, 1'b0, 1'b1, 1'b1);
      repeat (4) begin
         issue(wisc_pkg::ALU_ADD, 1'b0, $urandom, $urandom, $urandom, $urandom,
            wisc_pkg::WB_ALU, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ, 1'b0, 1'b0, 1'b1, 1'b0);
      end
      insert_bubbles(3);
      apply_reset();
      issue(wisc_pkg::ALU_SLL, 1'b0, $urandom, $urandom, $urandom, $urandom,
         wisc_pkg::WB_ALU, wisc_pkg::BR_NONE, wisc_pkg::SET_EQ, 1'b0, 1'b0, 1'b1, 1'b0);
      insert_bubbles(3);
   endtask

   initial begin
      #(20 * (TEST_CYCLES + 50));
      $display("watchdog expired, the tests did not finish within %0d cycles", TEST_CYCLES + 50);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   end

   initial begin
      void'($urandom(66));
      cyc         = 0;
      halt_cyc    = NEVER;
      last_taken  = -10;
      arst_n      = 1'b0;
      issue_valid = 1'b0;
      {pc_inc, rd_data_1, rd_data_2, sext_imm} = '0;
      {alu_src_imm, mem_en, mem_wr, wr_en, halt_req, wr_reg} = '0;
      alu_op  = wisc_pkg::ALU_ADD;
      br_kind = wisc_pkg::BR_NONE;
      set_sel = wisc_pkg::SET_EQ;
      wr_sel  = wisc_pkg::WB_ALU;
      apply_reset();
      test_alu_ops();
      test_set_and_imm();
      test_load_store();
      test_branches();
      test_bubbles();
      test_halt();
      insert_bubbles(4);
      assert (exp_cyc.size() == 0 && redir_cyc.size() == 0)
         else stop_with_error("expected results were still pending at the end");
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== wisc_backend.f ====
design/wisc_pkg.sv
design/alu_exec.sv
design/ex_mem_reg.sv
design/data_mem.sv
design/mem_wb_stage.sv
design/wisc_backend.sv
test/tb_wisc_backend.sv
